/* filelist.f */
rtl/s2m_pkg.sv
rtl/fifo_ram_2p.sv
rtl/stream_fifo.sv
rtl/axis_burst_writer.sv
rtl/stream_to_axi_top.sv
tb/stream_to_axi_checker.sv
tb/tb_stream_to_axi.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_stream_to_axi -f filelist.f -o tb_sim \
   > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* tb/tb_stream_to_axi.sv */
module tb_stream_to_axi;

   timeunit 1ns;
   timeprecision 1ps;

   import s2m_pkg::*;

   typedef logic [31:0] addr_t;

   localparam int TOTAL_WORDS     = 64 + 3 + 20 + 200 + 16 + 8;
   localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 2000;

   logic      clk;
   logic      arst_n;
   addr_t     config_addr;
   logic      config_valid;
   logic      config_ready;
   axi_data_t axis_data;
   logic      axis_valid;
   logic      axis_ready;
   addr_t     awaddr;
   axi_len_t  awlen;
   logic      awvalid;
   logic      awready;
   axi_data_t wdata;
   logic      wlast;
   logic      wvalid;
   logic      wready;
   logic      bvalid;

   // Slave model records written only by the slave process
   axi_data_t mem[addr_t];
   addr_t     aw_addr_q[$];
   axi_len_t  aw_len_q[$];
   int        beats_seen       = 0;
   int        wlast_errors     = 0;
   int        ready_low_cycles = 0;
   int        busy_open_cycles = 0;

   int          errors       = 0;
   int          tests_run    = 0;
   int          tests_failed = 0;
   logic        stall_en     = 1'b0;
   logic [31:0] stream_rng;
   string       test_name    = "reset";

   stream_to_axi_top #(
      .AXI_ADDR_W(32),
      .BURST_W   (3)
   ) u_dut (
      .clk_i         (clk),
      .arst_n_i      (arst_n),
      .config_addr_i (config_addr),
      .config_valid_i(config_valid),
      .config_ready_o(config_ready),
      .axis_data_i   (axis_data),
      .axis_valid_i  (axis_valid),
      .axis_ready_o  (axis_ready),
      .axi_awaddr_o  (awaddr),
      .axi_awlen_o   (awlen),
      .axi_awvalid_o (awvalid),
      .axi_awready_i (awready),
      .axi_wdata_o   (wdata),
      .axi_wlast_o   (wlast),
      .axi_wvalid_o  (wvalid),
      .axi_wready_i  (wready),
      .axi_bvalid_i  (bvalid)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the run was still busy after %0d cycles", WATCHDOG_CYCLES);
      $display("ERRORS FOUND");
      $finish;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Expected word i of a test stream
   function automatic axi_data_t ref_word(input axi_data_t seed, input int i);
      return seed ^ (axi_data_t'(i) * 32'h9e37_79b9);
   endfunction

   function automatic int total_errors();
      return errors + wlast_errors;
   endfunction

   // Outputs are sampled mid-cycle and inputs change 1 ns after the rising edge
   initial begin : slave_model
      logic [31:0] rng;
      int          pending_b;
      int          words_in;
      addr_t       cur_addr;
      axi_len_t    cur_len;
      axi_len_t    beat;
      rng       = 32'h5321efde;
      pending_b = 0;
      words_in  = 0;
      cur_addr  = '0;
      cur_len   = '0;
      beat      = '0;
      awready   = 1'b0;
      wready    = 1'b0;
      bvalid    = 1'b0;
      forever begin
         @(negedge clk);
         // Transfer open while words are buffered, beats run or a response is due
         if (config_ready &&
             (awvalid || wvalid || pending_b > 0 || words_in != beats_seen)) begin
            busy_open_cycles++;
         end
         if (axis_valid && axis_ready) begin
            words_in++;
         end
         if (awvalid && awready) begin
            aw_addr_q.push_back(awaddr);
            aw_len_q.push_back(awlen);
            cur_addr = awaddr;
            cur_len  = awlen;
            beat     = '0;
         end
         if (wvalid && wready) begin
            mem[cur_addr + 4 * addr_t'(beat)] = wdata;
            beats_seen++;
            if (wlast != (beat == cur_len)) begin
               $display("CHECK FAILED %s: expected wlast %0b, actual %0b on beat %0d at %h",
                        test_name, (beat == cur_len), wlast, beat, cur_addr);
               wlast_errors++;
            end
            if (wlast) begin
               pending_b++;
            end else begin
               beat++;
            end
         end
         if (bvalid) begin
            pending_b--;
         end
         if (stall_en && !axis_ready) begin
            ready_low_cycles++;
         end
         @(posedge clk);
         #1;
         rng     = xorshift(rng);
         awready = !stall_en || rng[0];
         wready  = !stall_en || rng[1] || rng[2];
         bvalid  = (pending_b > 0) && (!stall_en || rng[3]);
      end
   end

   task automatic report_error(input string msg);
      $display("ERROR: %s", msg);
      errors++;
   endtask

   task automatic check_word(input string name, input axi_data_t exp, input axi_data_t act);
      if (exp !== act) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (exp !== act) begin
         $display("CHECK FAILED %s: expected address %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_len(input string name, input axi_len_t exp, input axi_len_t act);
      if (exp !== act) begin
         $display("CHECK FAILED %s: expected awlen %0d, actual %0d", name, exp, act);
         errors++;
      end
   endtask

   task automatic load_address(input addr_t start);
      int cycles;
      cycles       = 0;
      config_addr  = start;
      config_valid = 1'b1;
      while (!config_ready && cycles < 200) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      @(posedge clk);
      #1;
      config_valid = 1'b0;
      if (cycles >= 200) begin
         report_error("config port never became ready");
      end
   endtask

   task automatic send_words(input axi_data_t seed, input int n, input bit gaps);
      int   i;
      logic accepted;
      for (i = 0; i < n; i++) begin
         stream_rng = xorshift(stream_rng);
         if (gaps && stream_rng[1:0] == 2'b00) begin
            axis_valid = 1'b0;
            @(posedge clk);
            #1;
         end
         axis_valid = 1'b1;
         axis_data  = ref_word(seed, i);
         accepted   = 1'b0;
         while (!accepted) begin
            // Ready only moves on a clock edge
            accepted = axis_ready;
            @(posedge clk);
            #1;
         end
      end
      axis_valid = 1'b0;
   endtask

   // Done once every beat is written and the writer is idle again
   task automatic wait_done(input int beats_start, input int n);
      int cycles;
      cycles = 0;
      while (!(beats_seen - beats_start >= n && config_ready) && cycles < n * 20 + 200) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (cycles >= n * 20 + 200) begin
         report_error($sformatf("transfer of %0d words did not complete", n));
      end
   endtask

   task automatic verify_bursts(input string name, input int first, input addr_t start,
                                input int n);
      addr_t next;
      int    beats;
      int    k;
      next  = start;
      beats = 0;
      for (k = first; k < aw_addr_q.size(); k++) begin
         check_addr(name, next, aw_addr_q[k]);
         if (int'(aw_addr_q[k][11:0]) + (int'(aw_len_q[k]) + 1) * 4 > PAGE_BYTES) begin
            report_error($sformatf("burst at %h crosses a 4 KB page", aw_addr_q[k]));
         end
         next  = aw_addr_q[k] + addr_t'((int'(aw_len_q[k]) + 1) * BYTES_PER_BEAT);
         beats = beats + int'(aw_len_q[k]) + 1;
      end
      if (beats != n) begin
         report_error($sformatf("%s: bursts carry %0d beats instead of %0d", name, beats, n));
      end
   endtask

   task automatic compare_memory(input string name, input addr_t start, input axi_data_t seed,
                                 input int n);
      addr_t a;
      int    i;
      for (i = 0; i < n; i++) begin
         a = start + addr_t'(i * BYTES_PER_BEAT);
         if (!mem.exists(a)) begin
            report_error($sformatf("%s: no write reached address %h", name, a));
         end else begin
            check_word(name, ref_word(seed, i), mem[a]);
         end
      end
   endtask

   task automatic transfer(input string name, input addr_t start, input axi_data_t seed,
                           input int n, input bit gaps, output int first);
      int beats_start;
      test_name   = name;
      first       = aw_addr_q.size();
      beats_start = beats_seen;
      load_address(start);
      send_words(seed, n, gaps);
      wait_done(beats_start, n);
      verify_bursts(name, first, start, n);
      compare_memory(name, start, seed, n);
   endtask

   task automatic finish_test(input string name, input int err_start);
      tests_run++;
      if (total_errors() == err_start) begin
         $display("test %s passed", name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", name, total_errors() - err_start);
      end
   endtask

   initial begin : stimulus
      int err_start;
      int first;
      int k;
      int low_start;
      int open_start;
      stream_rng   = xorshift(32'h5321efde);
      arst_n       = 1'b0;
      config_addr  = '0;
      config_valid = 1'b0;
      axis_data    = '0;
      axis_valid   = 1'b0;

      err_start = total_errors();
      repeat (10) begin
         @(posedge clk);
         #1;
         if (awvalid || wvalid || config_ready) begin
            report_error("AXI valid or config ready high during reset");
         end
      end
      arst_n = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      if (awvalid || wvalid || aw_addr_q.size() != 0) begin
         report_error("AXI activity before any data arrived");
      end
      if (!config_ready) begin
         report_error("config port not ready after reset");
      end
      finish_test("reset", err_start);

      err_start = total_errors();
      transfer("full_bursts", 32'h1000, 32'h1111_0000, 64, 1'b0, first);
      for (k = first; k < aw_len_q.size(); k++) begin
         check_len("full_bursts", 8'd7, aw_len_q[k]);
      end
      finish_test("full_bursts", err_start);

      err_start = total_errors();
      transfer("idle_flush", 32'h3000, 32'h2222_0000, 3, 1'b0, first);
      if (aw_len_q.size() != first + 1) begin
         report_error("idle stream did not give exactly one burst");
      end else begin
         check_len("idle_flush", 8'd2, aw_len_q[first]);
      end
      finish_test("idle_flush", err_start);

      // Three beats fit before the page end at 0x1000
      err_start = total_errors();
      transfer("page_boundary", 32'h0ff4, 32'h3333_0000, 20, 1'b0, first);
      if (aw_len_q.size() > first) begin
         check_len("page_boundary", 8'd2, aw_len_q[first]);
      end
      finish_test("page_boundary", err_start);

      err_start = total_errors();
      stall_en  = 1'b1;
      low_start = ready_low_cycles;
      transfer("back_pressure", 32'h4000, 32'h4444_0000, 200, 1'b1, first);
      stall_en = 1'b0;
      if (ready_low_cycles == low_start) begin
         report_error("axis_ready_o never dropped while the slave stalled");
      end
      finish_test("back_pressure", err_start);

      err_start  = total_errors();
      open_start = busy_open_cycles;
      transfer("config_gating", 32'h5000, 32'h5555_0000, 16, 1'b0, first);
      transfer("config_gating", 32'h6000, 32'h6666_0000, 8, 1'b0, first);
      if (busy_open_cycles != open_start) begin
         report_error("config port was ready while a transfer was in progress");
      end
      finish_test("config_gating", err_start);

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors());
      if (total_errors() == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* tb/stream_to_axi_checker.sv */
module stream_to_axi_checker #(
   parameter int AXI_ADDR_W = 32,
   parameter int BURST_W    = 3
) (
   input logic                  clk_i,
   input logic                  arst_n_i,
   input logic                  config_ready_i,
   input logic [AXI_ADDR_W-1:0] axi_awaddr_i,
   input s2m_pkg::axi_len_t     axi_awlen_i,
   input logic                  axi_awvalid_i,
   input logic                  axi_awready_i,
   input logic                  axi_wvalid_i,
   input logic                  axi_wready_i
);

   timeunit 1ns;
   timeprecision 1ps;

   import s2m_pkg::*;

   localparam int BURST_SIZE = 2 ** BURST_W;

   // AW holds with stable fields until accepted
   aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      axi_awvalid_i && !axi_awready_i |=>
         axi_awvalid_i && $stable(axi_awaddr_i) && $stable(axi_awlen_i))
      else $error("AW channel changed before awready");

   w_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      axi_wvalid_i && !axi_wready_i |=> axi_wvalid_i)
      else $error("wvalid dropped before wready");

   len_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      axi_awvalid_i |-> int'(axi_awlen_i) <= BURST_SIZE - 1)
      else $error("awlen above the maximum burst");

   // Last byte of the burst stays in the same 4 KB page
   page_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      axi_awvalid_i |->
         int'(axi_awaddr_i[11:0]) + (int'(axi_awlen_i) + 1) * BYTES_PER_BEAT <= PAGE_BYTES)
      else $error("burst crosses a 4 KB page");

   cfg_closed: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(config_ready_i && axi_wvalid_i))
      else $error("config_ready high during W beats");

endmodule

bind stream_to_axi_top stream_to_axi_checker #(
   .AXI_ADDR_W(AXI_ADDR_W),
   .BURST_W   (BURST_W)
) u_checker (
   .clk_i         (clk_i),
   .arst_n_i      (arst_n_i),
   .config_ready_i(config_ready_o),
   .axi_awaddr_i  (axi_awaddr_o),
   .axi_awlen_i   (axi_awlen_o),
   .axi_awvalid_i (axi_awvalid_o),
   .axi_awready_i (axi_awready_i),
   .axi_wvalid_i  (axi_wvalid_o),
   .axi_wready_i  (axi_wready_i)
);

/* rtl/stream_to_axi_top.sv */
module stream_to_axi_top #(
   parameter int AXI_ADDR_W = 32,
   parameter int BURST_W    = 3
) (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   // Configuration
   input  logic [AXI_ADDR_W-1:0] config_addr_i,
   input  logic                  config_valid_i,
   output logic                  config_ready_o,
   // Stream input
   input  s2m_pkg::axi_data_t    axis_data_i,
   input  logic                  axis_valid_i,
   output logic                  axis_ready_o,
   // AW channel
   output logic [AXI_ADDR_W-1:0] axi_awaddr_o,
   output s2m_pkg::axi_len_t     axi_awlen_o,
   output logic                  axi_awvalid_o,
   input  logic                  axi_awready_i,
   // W channel
   output s2m_pkg::axi_data_t    axi_wdata_o,
   output logic                  axi_wlast_o,
   output logic                  axi_wvalid_o,
   input  logic                  axi_wready_i,
   // B channel
   input  logic                  axi_bvalid_i
);

   import s2m_pkg::*;

   // Buffer holds two bursts
   localparam int BUFFER_W = BURST_W + 1;

   logic                fifo_rd_en;
   axi_data_t           fifo_data;
   logic                fifo_empty;
   logic                fifo_full;
   logic [BUFFER_W:0]   fifo_level;

   logic                ram_w_en;
   logic [BUFFER_W-1:0] ram_w_addr;
   axi_data_t           ram_w_data;
   logic                ram_r_en;
   logic [BUFFER_W-1:0] ram_r_addr;
   axi_data_t           ram_r_data;

   assign axis_ready_o = !fifo_full;

   axis_burst_writer #(
      .AXI_ADDR_W(AXI_ADDR_W),
      .BURST_W   (BURST_W)
   ) u_writer (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .config_addr_i (config_addr_i),
      .config_valid_i(config_valid_i),
      .config_ready_o(config_ready_o),
      .axis_valid_i  (axis_valid_i),
      .fifo_rd_en_o  (fifo_rd_en),
      .fifo_data_i   (fifo_data),
      .fifo_empty_i  (fifo_empty),
      .fifo_level_i  (fifo_level),
      .axi_awaddr_o  (axi_awaddr_o),
      .axi_awlen_o   (axi_awlen_o),
      .axi_awvalid_o (axi_awvalid_o),
      .axi_awready_i (axi_awready_i),
      .axi_wdata_o   (axi_wdata_o),
      .axi_wlast_o   (axi_wlast_o),
      .axi_wvalid_o  (axi_wvalid_o),
      .axi_wready_i  (axi_wready_i),
      .axi_bvalid_i  (axi_bvalid_i)
   );

   // Stream writes straight into the FIFO, full blocks via axis_ready_o
   stream_fifo #(
      .ADDR_W(BUFFER_W)
   ) u_fifo (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .w_en_i      (axis_valid_i),
      .w_data_i    (axis_data_i),
      .w_full_o    (fifo_full),
      .r_en_i      (fifo_rd_en),
      .r_data_o    (fifo_data),
      .r_empty_o   (fifo_empty),
      .level_o     (fifo_level),
      .ram_w_en_o  (ram_w_en),
      .ram_w_addr_o(ram_w_addr),
      .ram_w_data_o(ram_w_data),
      .ram_r_en_o  (ram_r_en),
      .ram_r_addr_o(ram_r_addr),
      .ram_r_data_i(ram_r_data)
   );

   fifo_ram_2p #(
      .DATA_W(DATA_W),
      .ADDR_W(BUFFER_W)
   ) u_ram (
      .clk_i   (clk_i),
      .w_en_i  (ram_w_en),
      .w_addr_i(ram_w_addr),
      .w_data_i(ram_w_data),
      .r_en_i  (ram_r_en),
      .r_addr_i(ram_r_addr),
      .r_data_o(ram_r_data)
   );

endmodule

/* rtl/axis_burst_writer.sv */
module axis_burst_writer #(
   parameter int AXI_ADDR_W = 32,
   parameter int BURST_W    = 3
) (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   // Configuration
   input  logic [AXI_ADDR_W-1:0] config_addr_i,
   input  logic                  config_valid_i,
   output logic                  config_ready_o,
   // Stream activity, only used to detect idle
   input  logic                  axis_valid_i,
   // FIFO read side
   output logic                  fifo_rd_en_o,
   input  s2m_pkg::axi_data_t    fifo_data_i,
   input  logic                  fifo_empty_i,
   input  logic [BURST_W+1:0]    fifo_level_i,
   // AW channel
   output logic [AXI_ADDR_W-1:0] axi_awaddr_o,
   output s2m_pkg::axi_len_t     axi_awlen_o,
   output logic                  axi_awvalid_o,
   input  logic                  axi_awready_i,
   // W channel
   output s2m_pkg::axi_data_t    axi_wdata_o,
   output logic                  axi_wlast_o,
   output logic                  axi_wvalid_o,
   input  logic                  axi_wready_i,
   // B channel
   input  logic                  axi_bvalid_i
);

   import s2m_pkg::*;

   localparam int BURST_SIZE = 2 ** BURST_W;

   // Beat count of one burst, 1 to BURST_SIZE
   typedef logic [BURST_W:0] beats_t;

   wr_state_t             state_q;
   wr_state_t             state_d;
   logic [AXI_ADDR_W-1:0] addr_q;
   logic [AXI_ADDR_W-1:0] addr_d;
   axi_len_t              awlen_q;
   axi_len_t              beat_q;
   logic                  armed_q;

   logic                  full_burst;
   logic                  last_burst;
   logic                  start_burst;
   logic                  w_fire;
   beats_t                raw_beats;
   beats_t                burst_beats;
   axi_len_t              burst_len;
   logic [AXI_ADDR_W-1:0] burst_bytes;

   // Burst decision
   assign full_burst  = (fifo_level_i >= (BURST_W + 2)'(BURST_SIZE));
   assign last_burst  = !fifo_empty_i && !full_burst && !axis_valid_i;
   assign start_burst = (full_burst || last_burst) && (state_q == WAIT_DATA);

   // Short bursts take whatever is buffered
   assign raw_beats = full_burst ? beats_t'(BURST_SIZE) : beats_t'(fifo_level_i);

   generate
      if (AXI_ADDR_W >= 13) begin : g_page_clip
         logic [12:0] page_beats;

         // Beats left up to the next 4 KB page
         assign page_beats = 13'((PAGE_BYTES - int'(addr_q[11:0])) / BYTES_PER_BEAT);

         always_comb begin
            burst_beats = raw_beats;
            if (13'(raw_beats) > page_beats) begin
               burst_beats = beats_t'(page_beats);
            end
         end
      end else begin : g_no_clip
         // Address space smaller than one page
         assign burst_beats = raw_beats;
      end
   endgenerate

   assign burst_len   = axi_len_t'(burst_beats - beats_t'(1));
   assign burst_bytes = AXI_ADDR_W'((int'(awlen_q) + 1) * BYTES_PER_BEAT);

   assign w_fire = axi_wvalid_o && axi_wready_i;

   // Channel outputs
   assign axi_awvalid_o = (state_q == START_BURST);
   assign axi_awaddr_o  = addr_q;
   assign axi_awlen_o   = awlen_q;
   assign axi_wvalid_o  = (state_q == SEND_BEATS);
   assign axi_wdata_o   = fifo_data_i;
   assign axi_wlast_o   = (state_q == SEND_BEATS) && (beat_q == awlen_q);

   // New address only between transfers with nothing buffered
   assign config_ready_o = armed_q && (state_q == WAIT_DATA) && fifo_empty_i;

   always_comb begin
      state_d      = state_q;
      addr_d       = addr_q;
      fifo_rd_en_o = 1'b0;

      if (config_valid_i && config_ready_o) begin
         addr_d = config_addr_i;
      end

      case (state_q)
         WAIT_DATA: begin
            // First read here so data is ready when W starts
            if (start_burst) begin
               fifo_rd_en_o = 1'b1;
               state_d      = START_BURST;
            end
         end
         START_BURST: begin
            if (axi_awready_i) begin
               state_d = SEND_BEATS;
            end
         end
         SEND_BEATS: begin
            if (w_fire) begin
               if (axi_wlast_o) begin
                  addr_d  = addr_q + burst_bytes;
                  state_d = WAIT_BRESP;
               end else begin
                  fifo_rd_en_o = 1'b1;
               end
            end
         end
         WAIT_BRESP: begin
            // Response code is not inspected
            if (axi_bvalid_i) begin
               state_d = WAIT_DATA;
            end
         end
         default: state_d = WAIT_DATA;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= WAIT_DATA;
         addr_q  <= '0;
         beat_q  <= '0;
         armed_q <= 1'b0;
      end else begin
         state_q <= state_d;
         addr_q  <= addr_d;
         // Config ready waits one clock after reset
         armed_q <= 1'b1;
         if (start_burst) begin
            beat_q <= '0;
         end else if (w_fire && !axi_wlast_o) begin
            beat_q <= beat_q + 1'b1;
         end
      end
   end

   // Length is latched at the burst decision
   always_ff @(posedge clk_i) begin
      if (start_burst) begin
         awlen_q <= burst_len;
      end
   end

endmodule

/* rtl/stream_fifo.sv */
module stream_fifo #(
   parameter int ADDR_W = 4
) (
   input  logic               clk_i,
   input  logic               arst_n_i,
   // Write side
   input  logic               w_en_i,
   input  s2m_pkg::axi_data_t w_data_i,
   output logic               w_full_o,
   // Read side
   input  logic               r_en_i,
   output s2m_pkg::axi_data_t r_data_o,
   output logic               r_empty_o,
   // Number of stored words
   output logic [ADDR_W:0]    level_o,
   // External RAM
   output logic               ram_w_en_o,
   output logic [ADDR_W-1:0]  ram_w_addr_o,
   output s2m_pkg::axi_data_t ram_w_data_o,
   output logic               ram_r_en_o,
   output logic [ADDR_W-1:0]  ram_r_addr_o,
   input  s2m_pkg::axi_data_t ram_r_data_i
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [ADDR_W-1:0] w_ptr_q;
   logic [ADDR_W-1:0] r_ptr_q;
   logic [ADDR_W:0]   level_q;

   logic w_fire;
   logic r_fire;

   // Status flags from the level counter
   assign w_full_o  = (level_q == (ADDR_W + 1)'(DEPTH));
   assign r_empty_o = (level_q == '0);
   assign level_o   = level_q;

   // Requests past full or empty are dropped
   assign w_fire = w_en_i && !w_full_o;
   assign r_fire = r_en_i && !r_empty_o;

   // RAM write port
   assign ram_w_en_o   = w_fire;
   assign ram_w_addr_o = w_ptr_q;
   assign ram_w_data_o = w_data_i;

   // RAM read port, data returns one cycle later
   assign ram_r_en_o   = r_fire;
   assign ram_r_addr_o = r_ptr_q;
   assign r_data_o     = ram_r_data_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
      end else begin
         if (w_fire) begin
            w_ptr_q <= w_ptr_q + 1'b1;
         end
         if (r_fire) begin
            r_ptr_q <= r_ptr_q + 1'b1;
         end
         // Read and write together keep the level
         case ({w_fire, r_fire})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

endmodule

/* rtl/fifo_ram_2p.sv */
module fifo_ram_2p #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 4
) (
   input  logic               clk_i,
   // Write port
   input  logic               w_en_i,
   input  logic [ADDR_W-1:0]  w_addr_i,
   input  s2m_pkg::axi_data_t w_data_i,
   // Read port
   input  logic               r_en_i,
   input  logic [ADDR_W-1:0]  r_addr_i,
   output s2m_pkg::axi_data_t r_data_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem[DEPTH];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // Registered read, output holds while r_en_i is low
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

/* rtl/s2m_pkg.sv */
package s2m_pkg;

   // Stream word and AXI data beat width
   localparam int DATA_W = 32;

   // Byte step from one beat to the next
   localparam int BYTES_PER_BEAT = DATA_W / 8;

   // AXI bursts must stay inside one page of this size
   localparam int PAGE_BYTES = 4096;

   // One stream word or one W beat
   typedef logic [DATA_W-1:0] axi_data_t;

   // AXI length field, beats minus one
   typedef logic [7:0] axi_len_t;

   // Burst writer states
   typedef enum logic [1:0] {
      WAIT_DATA   = 2'd0,
      START_BURST = 2'd1,
      SEND_BEATS  = 2'd2,
      WAIT_BRESP  = 2'd3
   } wr_state_t;

endpackage
